//--- all.f
src/dif_pkg.sv
src/stream_fifo.sv
src/cmd_decoder.sv
src/sc_shifter.sv
src/dout_packer.sv
src/skiroc_dif_top.sv
sim/tb_skiroc_dif.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_skiroc_dif \
	-f all.f \
	-o tb_skiroc_dif

./obj_dir/tb_skiroc_dif

//--- sim/tb_skiroc_dif.sv
/*
 * Testbench for the digital interface top level
 * Drives host commands and chip readout bursts, checks serial config bits,
 * readout words and the overflow flag against a reference model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_skiroc_dif;

	localparam int SC_BYTES   = 8;
	localparam int SR_HALF    = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int NBITS      = SC_BYTES * 8;
	// Four config runs near 260 cycles each plus readout near 250
	localparam int TIMEOUT_CYCLES = 4000;

	logic               Clk_Out_2_All;
	logic               rst_i;
	dif_pkg::cmd_word_t cmd_i;
	logic               cmd_valid_i;
	logic               cmd_ready_o;
	logic               sr_ck_o;
	logic               sr_in_o;
	logic               sc_done_o;
	logic               dout_b_i;
	logic               transmit_on_b_i;
	dif_pkg::ro_word_t  data_o;
	logic               data_valid_o;
	logic               data_ready_i;
	logic               overflow_o;

	// Reference model state
	logic [7:0]         exp_image [SC_BYTES];
	logic               exp_bits [$];          // Bits the next run must shift
	logic               cap_q [$];             // Bits seen on sr_in_o
	dif_pkg::ro_word_t  exp_words [$];         // Words still due on data_o
	logic               exp_ovf;
	logic [31:0]        lcg_state;
	logic               sr_ck_q;
	int                 done_count;
	int                 runs_started;
	int                 cycle_count;

	skiroc_dif_top #(.SC_BYTES(SC_BYTES), .SR_HALF(SR_HALF), .FIFO_DEPTH(FIFO_DEPTH))
	u_skiroc_dif_top (.*);

	always #4 Clk_Out_2_All = ~Clk_Out_2_All;   // 8 ns period

	////////////////////
	// Failure reporting
	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED at %0t: %s expected %0h got %0h", $time, sig, exp, act);
		$display("Verification failed");
		$fatal(1, "Mismatch on %s", sig);
	endtask

	task automatic report_fault(input string what);
		$display("FAILED at %0t: %s", $time, what);
		$display("Verification failed");
		$fatal(1, "%s", what);
	endtask

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];    // Upper bits spread better
	endfunction

	////////////////////
	// Run limit
	always @(posedge Clk_Out_2_All)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout, no progress after %0d cycles", cycle_count);
			$display("Verification failed");
			$fatal(1, "Run stopped by timeout");
		end
	end

	////////////////////
	// Monitors
	always @(posedge Clk_Out_2_All)
	begin
		sr_ck_q <= sr_ck_o;
		if (!rst_i && sr_ck_o && !sr_ck_q)
			cap_q.push_back(sr_in_o);     // Chip samples on the rise
		if (!rst_i && sc_done_o)
		begin
			done_count <= done_count + 1;
			assert (cap_q.size() == NBITS)
			else report_mismatch("sr_in_o bit count at sc_done_o", NBITS, 32'(cap_q.size()));
		end
		if (!rst_i && data_valid_o && data_ready_i)
		begin
			assert (exp_words.size() > 0) else report_fault("data_o word with none expected");
			assert (data_o == exp_words[0])
			else report_mismatch("data_o", 32'(exp_words[0]), 32'(data_o));
			void'(exp_words.pop_front());
		end
	end

	a_done_pulse : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		sc_done_o |=> !sc_done_o)
		else report_mismatch("sc_done_o", 0, 1);

	// Stalled output word stays put
	a_ro_hold : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		data_valid_o && !data_ready_i |=> data_valid_o && $stable(data_o))
		else report_fault("data_o moved while data_ready_i was low");

	////////////////////
	// Stimulus tasks
	task automatic send_cmd(input logic [7:0] opcode, input logic [7:0] arg);
		cmd_i       = '{opcode: opcode, arg: arg};
		cmd_valid_i = 1'b1;
		while (!cmd_ready_o)
		begin
			@(posedge Clk_Out_2_All);
			#1;
		end
		@(posedge Clk_Out_2_All);    // Transfer on this edge
		#1;
		cmd_valid_i = 1'b0;
	endtask

	task automatic send_sc_byte(input logic [3:0] idx, input logic [7:0] val);
		send_cmd({dif_pkg::OP_SC_BYTE, idx}, val);
		if (idx < SC_BYTES)
			exp_image[idx] = val;   // Out of range index changes nothing
	endtask

	task automatic start_config();
		exp_bits.delete();
		cap_q.delete();
		for (int b = 0; b < SC_BYTES; b++)
			for (int k = 7; k >= 0; k--)
				exp_bits.push_back(exp_image[b][k]);   // Byte 0 first, MSB first
		send_cmd(dif_pkg::OP_SC_START, 8'h00);
		runs_started++;
	endtask

	task automatic wait_done();
		while (done_count < runs_started)
		begin
			@(posedge Clk_Out_2_All);
			#1;
		end
	endtask

	task automatic check_run();
		assert (cap_q.size() == NBITS)
		else report_mismatch("sr_in_o bit count", NBITS, 32'(cap_q.size()));
		for (int i = 0; i < NBITS; i++)
			assert (cap_q[i] == exp_bits[i])
			else report_mismatch($sformatf("sr_in_o bit %0d", i), 32'(exp_bits[i]),
				32'(cap_q[i]));
	endtask

	task automatic send_burst(input logic [15:0] burst);
		dif_pkg::ro_word_t w;
		transmit_on_b_i = 1'b0;
		for (int i = 15; i >= 0; i--)
		begin
			dout_b_i = burst[i];          // Line level with bit 15 first
			@(posedge Clk_Out_2_All);
			#1;
		end
		transmit_on_b_i = 1'b1;
		dout_b_i        = 1'b1;
		w = '{hi_byte: ~burst[7:0], lo_byte: ~burst[15:8]};   // Inverted and swapped
		if (exp_words.size() < FIFO_DEPTH)
			exp_words.push_back(w);
		else
			exp_ovf = 1'b1;                // Full FIFO drops it
		@(posedge Clk_Out_2_All);        // Idle gap between bursts
		#1;
	endtask

	task automatic wait_drain();
		while (exp_words.size() != 0)
		begin
			@(posedge Clk_Out_2_All);
			#1;
		end
	endtask

	////////////////////
	// Main sequence
	initial
	begin
		logic [15:0] r;
		Clk_Out_2_All   = 1'b0;
		rst_i           = 1'b1;
		cmd_i           = '0;
		cmd_valid_i     = 1'b0;
		dout_b_i        = 1'b1;   // Line idles high
		transmit_on_b_i = 1'b1;
		data_ready_i    = 1'b1;
		lcg_state       = 32'd55;
		exp_ovf         = 1'b0;
		done_count      = 0;
		runs_started    = 0;
		cycle_count     = 0;
		sr_ck_q         = 1'b0;
		for (int b = 0; b < SC_BYTES; b++)
			exp_image[b] = 8'h00;
		repeat (8) @(posedge Clk_Out_2_All);
		#1;
		rst_i = 1'b0;

		// Reset state
		assert (cmd_ready_o) else report_mismatch("cmd_ready_o", 1, 32'(cmd_ready_o));
		assert (!sr_ck_o) else report_mismatch("sr_ck_o", 0, 32'(sr_ck_o));
		assert (!sc_done_o) else report_mismatch("sc_done_o", 0, 32'(sc_done_o));
		assert (!data_valid_o) else report_mismatch("data_valid_o", 0, 32'(data_valid_o));
		assert (!overflow_o) else report_mismatch("overflow_o", 0, 32'(overflow_o));

		// Full image then shift
		for (int b = 0; b < SC_BYTES; b++)
		begin
			r = next_rand();
			send_sc_byte(4'(b), r[15:8]);
		end
		start_config();
		wait_done();
		check_run();

		// Index 9 lies past the image
		r = next_rand();
		send_sc_byte(4'd9, r[15:8]);
		start_config();
		wait_done();
		check_run();

		// Commands queue up behind a running shift
		start_config();
		r = next_rand();
		send_sc_byte(4'd2, r[15:8]);
		send_sc_byte(4'd5, r[7:0]);
		r = next_rand();
		send_sc_byte(4'd2, r[15:8]);    // Later write to same byte wins
		send_sc_byte(4'd7, r[7:0]);
		assert (!cmd_ready_o) else report_mismatch("cmd_ready_o", 0, 32'(cmd_ready_o));
		assert (done_count < runs_started) else report_fault("run ended before FIFO filled");
		r = next_rand();
		send_sc_byte(4'd0, r[15:8]);    // Waits for the run to end
		wait_done();
		check_run();
		start_config();
		wait_done();
		check_run();

		// Readout with no back-pressure
		repeat (8) send_burst(next_rand());
		wait_drain();
		assert (!overflow_o) else report_mismatch("overflow_o", 0, 32'(overflow_o));

		// Readout against a stalled sink
		data_ready_i = 1'b0;
		repeat (6) send_burst(next_rand());
		assert (overflow_o == exp_ovf) else report_mismatch("overflow_o", 32'(exp_ovf),
			32'(overflow_o));
		assert (data_valid_o) else report_mismatch("data_valid_o", 1, 32'(data_valid_o));
		data_ready_i = 1'b1;
		wait_drain();
		assert (overflow_o) else report_mismatch("overflow_o", 1, 32'(overflow_o));
		send_cmd(dif_pkg::OP_CLR_OVF, 8'h00);
		for (int n = 0; n < 8 && overflow_o; n++)
		begin
			@(posedge Clk_Out_2_All);
			#1;
		end
		assert (!overflow_o) else report_mismatch("overflow_o", 0, 32'(overflow_o));

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/skiroc_dif_top.sv
/*
 * Digital interface top level
 * Command FIFO, decoder, slow-control shifter, readout packer and FIFO
 */
`timescale 1ns/100ps
`default_nettype none

module skiroc_dif_top #(
	parameter int SC_BYTES   = 8,   // Image size
	parameter int SR_HALF    = 2,   // Serial half period in cycles
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic               Clk_Out_2_All,
	input  wire logic               rst_i,
	// Host command stream
	input  wire dif_pkg::cmd_word_t cmd_i,
	input  wire logic               cmd_valid_i,
	output logic                    cmd_ready_o,
	// Slow control to chip
	output logic                    sr_ck_o,
	output logic                    sr_in_o,
	output logic                    sc_done_o,
	// Chip readout
	input  wire logic               dout_b_i,
	input  wire logic               transmit_on_b_i,
	output dif_pkg::ro_word_t       data_o,
	output logic                    data_valid_o,
	input  wire logic               data_ready_i,
	output logic                    overflow_o
);

	dif_pkg::cmd_word_t        dec_cmd;      // FIFO head to decoder
	logic                      dec_valid;
	logic                      dec_ready;
	logic [SC_BYTES-1:0][7:0]  sc_image;
	logic                      sc_start;
	logic                      sc_busy;
	logic                      clr_ovf;
	dif_pkg::ro_word_t         pk_word;      // Packer to readout FIFO
	logic                      pk_valid;
	logic                      pk_ready;

	if (SC_BYTES < 1 || SC_BYTES > dif_pkg::MAX_SC_BYTES)
	begin : g_bad_sc_bytes
		$error("SC_BYTES outside the 4 bit index range");
	end
	if ($bits(dif_pkg::cmd_word_t) != dif_pkg::CMD_W)
	begin : g_bad_cmd_w
		$error("Command layout does not match CMD_W");
	end

	////////////////////
	// Command path
	stream_fifo #(.T(dif_pkg::cmd_word_t), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.in_i          (cmd_i),
		.in_valid_i    (cmd_valid_i),
		.in_ready_o    (cmd_ready_o),
		.out_o         (dec_cmd),
		.out_valid_o   (dec_valid),
		.out_ready_i   (dec_ready)
	);

	cmd_decoder #(.SC_BYTES(SC_BYTES)) u_cmd_decoder (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.cmd_i         (dec_cmd),
		.cmd_valid_i   (dec_valid),
		.cmd_ready_o   (dec_ready),
		.busy_i        (sc_busy),
		.sc_image_o    (sc_image),
		.sc_start_o    (sc_start),
		.clr_ovf_o     (clr_ovf)
	);

	sc_shifter #(.SC_BYTES(SC_BYTES), .SR_HALF(SR_HALF)) u_sc_shifter (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.sc_image_i    (sc_image),
		.sc_start_i    (sc_start),
		.busy_o        (sc_busy),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.sc_done_o     (sc_done_o)
	);

	////////////////////
	// Readout path
	dout_packer u_dout_packer (
		.Clk_Out_2_All   (Clk_Out_2_All),
		.rst_i           (rst_i),
		.dout_b_i        (dout_b_i),
		.transmit_on_b_i (transmit_on_b_i),
		.clr_ovf_i       (clr_ovf),
		.word_o          (pk_word),
		.word_valid_o    (pk_valid),
		.word_ready_i    (pk_ready),
		.overflow_o      (overflow_o)
	);

	stream_fifo #(.T(dif_pkg::ro_word_t), .DEPTH(FIFO_DEPTH)) u_ro_fifo (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.in_i          (pk_word),
		.in_valid_i    (pk_valid),
		.in_ready_o    (pk_ready),
		.out_o         (data_o),
		.out_valid_o   (data_valid_o),
		.out_ready_i   (data_ready_i)
	);

endmodule

`default_nettype wire

//--- src/dout_packer.sv
/*
 * Readout packer
 * Gathers active-low serial chip data into byte-swapped 16-bit words
 * and keeps a sticky overflow flag
 */
`timescale 1ns/100ps
`default_nettype none

module dout_packer (
	input  wire logic         Clk_Out_2_All,
	input  wire logic         rst_i,
	input  wire logic         dout_b_i,         // Active low serial data
	input  wire logic         transmit_on_b_i,  // Low during a burst
	input  wire logic         clr_ovf_i,
	output dif_pkg::ro_word_t word_o,
	output logic              word_valid_o,
	input  wire logic         word_ready_i,
	output logic              overflow_o
);

	localparam int W   = dif_pkg::WORD_W;
	localparam int BCW = $clog2(W);

	logic [W-1:0]   shreg;       // Bits gathered so far
	logic [W-1:0]   assembled;   // Gathered bits plus current one
	logic [BCW-1:0] bcnt;        // Position in the word
	logic           sample;

	assign sample    = ~transmit_on_b_i;
	assign assembled = {shreg[W-2:0], ~dout_b_i};   // First bit ends up at 15

	////////////////////
	// Byte swap before the FIFO
	assign word_o = '{hi_byte: assembled[7:0], lo_byte: assembled[15:8]};

	// Offered on the edge that takes the 16th bit
	assign word_valid_o = sample & (bcnt == BCW'(W - 1));

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (sample)
			shreg <= assembled;
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			bcnt       <= '0;
			overflow_o <= 1'b0;
		end
		else
		begin
			if (!sample)
				bcnt <= '0;          // Restart between bursts
			else
				bcnt <= bcnt + 1'b1; // Wraps after each word
			// Full FIFO drops the word
			if (word_valid_o && !word_ready_i)
				overflow_o <= 1'b1;
			else if (clr_ovf_i)
				overflow_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/sc_shifter.sv
/*
 * Slow-control serial shifter
 * Sends the image byte 0 first, MSB first, on a divided clock
 */
`timescale 1ns/100ps
`default_nettype none

module sc_shifter #(
	parameter int SC_BYTES = 8,
	parameter int SR_HALF  = 2
) (
	input  wire logic                      Clk_Out_2_All,
	input  wire logic                      rst_i,
	input  wire logic [SC_BYTES-1:0][7:0]  sc_image_i,
	input  wire logic                      sc_start_i,
	output logic                           busy_o,
	output logic                           sr_ck_o,    // Chip samples on rise
	output logic                           sr_in_o,
	output logic                           sc_done_o
);

	localparam int NBITS = SC_BYTES * 8;                  // Bits per run
	localparam int BCW   = $clog2(NBITS);
	localparam int HCW   = (SR_HALF > 1) ? $clog2(SR_HALF) : 1;

	logic [NBITS-1:0] image_flat;   // Byte 0 at the top
	logic [NBITS-1:0] shreg;        // Top bit drives the line
	logic [HCW-1:0]   hcnt;         // Cycles into the half period
	logic [BCW-1:0]   bcnt;         // Bits already sent
	logic             half_end;
	logic             last_bit;

	for (genvar b = 0; b < SC_BYTES; b++)
	begin : g_flat
		assign image_flat[(SC_BYTES-1-b)*8 +: 8] = sc_image_i[b];
	end

	assign half_end = (hcnt == HCW'(SR_HALF - 1));
	assign last_bit = (bcnt == BCW'(NBITS - 1));
	assign sr_in_o  = shreg[NBITS-1];

	////////////////////
	// Serial clock and data
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			busy_o    <= 1'b0;
			sr_ck_o   <= 1'b0;
			sc_done_o <= 1'b0;
			hcnt      <= '0;
			bcnt      <= '0;
			shreg     <= '0;    // Line idles low
		end
		else
		begin
			sc_done_o <= 1'b0;
			if (!busy_o)
			begin
				if (sc_start_i)
				begin
					busy_o  <= 1'b1;
					shreg   <= image_flat;    // First bit on the line now
					hcnt    <= '0;
					bcnt    <= '0;
					sr_ck_o <= 1'b0;
				end
			end
			else if (half_end)
			begin
				hcnt    <= '0;
				sr_ck_o <= ~sr_ck_o;
				if (sr_ck_o)
				begin
					// Clock falls so data may move
					shreg <= {shreg[NBITS-2:0], 1'b0};
					bcnt  <= bcnt + 1'b1;
					if (last_bit)
					begin
						busy_o    <= 1'b0;
						sc_done_o <= 1'b1;  // Right after the last rise
					end
				end
			end
			else
				hcnt <= hcnt + 1'b1;
		end
	end

	// Data never moves while the chip clock is high
	a_data_stable : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		sr_ck_o |-> $stable(sr_in_o));

endmodule

`default_nettype wire

//--- src/cmd_decoder.sv
/*
 * Host command decoder
 * Builds the configuration image and raises start and clear pulses
 */
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder #(
	parameter int SC_BYTES = 8
) (
	input  wire logic                Clk_Out_2_All,
	input  wire logic                rst_i,
	input  wire dif_pkg::cmd_word_t  cmd_i,
	input  wire logic                cmd_valid_i,
	output logic                     cmd_ready_o,
	input  wire logic                busy_i,      // Shifter running
	output logic [SC_BYTES-1:0][7:0] sc_image_o,  // Configuration image
	output logic                     sc_start_o,
	output logic                     clr_ovf_o
);

	logic       accept;    // Command taken this edge
	logic [3:0] op_hi;     // Operation nibble
	logic [3:0] op_idx;    // Target byte for image writes
	logic       is_byte;
	logic       is_start;
	logic       is_clr;

	// Blocked during a run and during the start cycle itself
	assign cmd_ready_o = ~busy_i & ~sc_start_o;
	assign accept      = cmd_valid_i & cmd_ready_o;

	assign op_hi    = cmd_i.opcode[7:4];
	assign op_idx   = cmd_i.opcode[3:0];
	assign is_byte  = (op_hi == dif_pkg::OP_SC_BYTE);
	assign is_start = (cmd_i.opcode == dif_pkg::OP_SC_START);
	assign is_clr   = (cmd_i.opcode == dif_pkg::OP_CLR_OVF);

	////////////////////
	// Image and pulses
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			sc_image_o <= '0;    // Chip config starts blank
			sc_start_o <= 1'b0;
			clr_ovf_o  <= 1'b0;
		end
		else
		begin
			sc_start_o <= accept & is_start;   // One cycle wide
			clr_ovf_o  <= accept & is_clr;
			if (accept && is_byte)
			begin
				// Index past the image matches no slot
				for (int b = 0; b < SC_BYTES; b++)
				begin
					if (op_idx == 4'(b))
						sc_image_o[b] <= cmd_i.arg;
				end
			end
		end
	end

	// Start only launches an idle shifter
	a_start_idle : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		$rose(sc_start_o) |-> !busy_i);

	// Shifter picks up every start on the next edge
	a_start_taken : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		sc_start_o |=> busy_i);

endmodule

`default_nettype wire

//--- src/stream_fifo.sv
/*
 * Small valid/ready FIFO
 * Circular buffer shared by the command and readout streams
 */
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
	parameter type T     = logic [15:0],
	parameter int  DEPTH = 4
) (
	input  wire logic Clk_Out_2_All,
	input  wire logic rst_i,
	input  wire T     in_i,
	input  wire logic in_valid_i,
	output logic      in_ready_o,
	output T          out_o,
	output logic      out_valid_o,
	input  wire logic out_ready_i
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
	localparam int CW = $clog2(DEPTH + 1);                // Count width

	T              mem [DEPTH];     // Payload slots
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;           // Entries held
	logic          push;
	logic          pop;

	assign in_ready_o  = (count != CW'(DEPTH));   // Not full
	assign out_valid_o = (count != '0);
	assign out_o       = mem[rd_ptr];             // Head entry
	assign push        = in_valid_i & in_ready_o;
	assign pop         = out_valid_o & out_ready_i;

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (push)
			mem[wr_ptr] <= in_i;
	end

	////////////////////
	// Pointers and count
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at end
			if (pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Idle or push with pop
			endcase
		end
	end

	a_count_bound : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		count <= CW'(DEPTH));

	// Stalled head stays put until taken
	a_head_hold : assert property (@(posedge Clk_Out_2_All) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

`default_nettype wire

//--- src/dif_pkg.sv
/*
 * Shared definitions for the front-end chip digital interface
 * Command and readout word layouts, opcodes and widths
 */
`default_nettype none

package dif_pkg;

	////////////////////
	// Host commands
	////////////////////
	localparam int CMD_W = 16;                  // Host command word width

	// One host command word
	typedef struct packed {
		logic [7:0] opcode;                     // Upper nibble selects operation
		logic [7:0] arg;                        // Byte value for image writes
	} cmd_word_t;

	localparam logic [3:0] OP_SC_BYTE  = 4'hA;  // Low nibble holds byte index
	localparam logic [7:0] OP_SC_START = 8'hB0; // Shift image into the chip
	localparam logic [7:0] OP_CLR_OVF  = 8'hC0; // Drop readout overflow flag

	// Largest image a 4 bit index reaches
	localparam int MAX_SC_BYTES = 16;

	////////////////////
	// Readout words
	////////////////////
	localparam int WORD_W = 16;                 // Readout word width

	// One readout word after the byte swap
	typedef struct packed {
		logic [7:0] hi_byte;
		logic [7:0] lo_byte;
	} ro_word_t;

endpackage

`default_nettype wire
